/* bench/ex1_checker.sv */
`timescale 1ns/1ns

module ex1_checker (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  int                   idx_i,
    input  logic                 chk_res_i,
    input  ex1_pkg::ex1_out_t    exp_out_i,
    input  ex1_pkg::br_res_t     exp_br_i,
    input  ex1_pkg::dcache_req_t exp_dc_i,
    input  ex1_pkg::ex1_out_t    out_i,
    input  ex1_pkg::br_res_t     br_i,
    input  ex1_pkg::dcache_req_t dc_i,
    output int                   errors_o,
    output int                   checked_o
);

    int err_cnt = 0;
    int chk_cnt = 0;

    assign errors_o  = err_cnt;
    assign checked_o = chk_cnt;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t entry %0d %s got %h expected %h",
                     $time, idx_i, name, got, exp);
            err_cnt++;
        end
    endtask

    // outputs settle after the rising edge, sample mid cycle
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            check_val("out.valid", 64'(out_i.valid), 64'(0));
            check_val("dcache.valid", 64'(dc_i.valid), 64'(0));
            check_val("br.is_branch", 64'(br_i.is_branch), 64'(0));
            check_val("br.dir_fail", 64'(br_i.dir_fail), 64'(0));
            check_val("br.addr_fail", 64'(br_i.addr_fail), 64'(0));
        end else if (en_i) begin
            chk_cnt++;
            check_val("out.valid", 64'(out_i.valid), 64'(exp_out_i.valid));
            check_val("br.is_branch", 64'(br_i.is_branch), 64'(exp_br_i.is_branch));
            check_val("br.dir_fail", 64'(br_i.dir_fail), 64'(exp_br_i.dir_fail));
            check_val("br.addr_fail", 64'(br_i.addr_fail), 64'(exp_br_i.addr_fail));
            check_val("dcache.valid", 64'(dc_i.valid), 64'(exp_dc_i.valid));
            if (exp_out_i.valid) begin
                check_val("out.rd", 64'(out_i.rd), 64'(exp_out_i.rd));
                check_val("out.wr_rd", 64'(out_i.wr_rd), 64'(exp_out_i.wr_rd));
                if (chk_res_i) begin
                    check_val("out.result", 64'(out_i.result), 64'(exp_out_i.result));
                end
            end
            if (exp_br_i.is_branch) begin
                check_val("br.taken", 64'(br_i.taken), 64'(exp_br_i.taken));
                check_val("br.fact_pc", 64'(br_i.fact_pc), 64'(exp_br_i.fact_pc));
                check_val("br.fact_tpc", 64'(br_i.fact_tpc), 64'(exp_br_i.fact_tpc));
            end
            if (exp_dc_i.valid) begin
                check_val("dcache.op", 64'(dc_i.op), 64'(exp_dc_i.op));
                check_val("dcache.wtype", 64'(dc_i.wtype), 64'(exp_dc_i.wtype));
                check_val("dcache.addr", 64'(dc_i.addr), 64'(exp_dc_i.addr));
                check_val("dcache.wdata", 64'(dc_i.wdata), 64'(exp_dc_i.wdata));
                check_val("dcache.is_atom", 64'(dc_i.is_atom), 64'(exp_dc_i.is_atom));
            end
        end
    end

endmodule

/* bench/tb_ex1.sv */
`timescale 1ns/1ns
`include "ex1_cfg.svh"

module tb_ex1;

    typedef struct packed {
        ex1_pkg::issue_t                         iss;
        ex1_pkg::fwd_src_t [`EX1_FWD_SLOTS-1:0]  fwd;
        ex1_pkg::word_t                          tid;
        logic [63:0]                             cnt;
        logic                                    ptaken;
        ex1_pkg::word_t                          ppc;
        logic                                    flush;
        logic                                    rnd_side;  // side inputs unused
        logic                                    chk_res;
        ex1_pkg::ex1_out_t                       exp_out;
        ex1_pkg::br_res_t                        exp_br;
        ex1_pkg::dcache_req_t                    exp_dc;
    } vec_t;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    ex1_pkg::issue_t      issue;
    ex1_pkg::fwd_src_t    fwd [`EX1_FWD_SLOTS];
    ex1_pkg::word_t       tid;
    logic [63:0]          cnt;
    logic                 ptaken;
    ex1_pkg::word_t       ppc;
    ex1_pkg::ex1_out_t    out;
    ex1_pkg::br_res_t     br;
    ex1_pkg::dcache_req_t dc;

    vec_t        vecs[$];
    vec_t        cur;
    int          n_vec = 0;
    int          cur_idx = 0;
    logic        cur_live = 1'b0;
    int          chk_idx = 0;
    logic        chk_en = 1'b0;
    logic [31:0] lfsr = 32'h6378_3011;
    int          errors;
    int          checked;

    ex1_stage uut (
        .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush), .issue_i (issue), .fwd_i (fwd),
        .tid_i (tid), .stable_counter_i (cnt), .predict_taken_i (ptaken),
        .predict_pc_i (ppc), .out_o (out), .br_o (br), .dcache_o (dc)
    );

    always @(posedge clk) begin
        chk_idx <= cur_idx;
        chk_en  <= cur_live;
    end

    ex1_checker u_checker (
        .clk_i (clk), .rst_n_i (rst_n), .en_i (chk_en), .idx_i (chk_idx),
        .chk_res_i (vecs[chk_idx].chk_res), .exp_out_i (vecs[chk_idx].exp_out),
        .exp_br_i (vecs[chk_idx].exp_br), .exp_dc_i (vecs[chk_idx].exp_dc),
        .out_i (out), .br_i (br), .dc_i (dc), .errors_o (errors), .checked_o (checked)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic alu_vec(input ex1_pkg::alu_op_t op, input ex1_pkg::src1_sel_t s1,
                           input ex1_pkg::src2_sel_t s2, input logic [31:0] rjd,
                           input logic [31:0] rkd, input logic [31:0] imm,
                           input logic [31:0] res);
        cur = '0;
        cur.iss.valid        = 1'b1;
        cur.iss.pc           = 32'h1C00_0000;
        cur.iss.uop.alu_op   = op;
        cur.iss.uop.src1_sel = s1;
        cur.iss.uop.src2_sel = s2;
        cur.iss.uop.mem_size = ex1_pkg::size_word;
        cur.iss.uop.wr_rd    = 1'b1;
        cur.iss.imm          = imm;
        cur.iss.rj           = 5'd1;
        cur.iss.rk           = 5'd2;
        cur.iss.rd           = 5'd3;
        cur.iss.rj_data      = rjd;
        cur.iss.rk_data      = rkd;
        cur.tid              = 32'h0000_0007;
        cur.cnt              = 64'h1111_2222_3333_4444;
        cur.rnd_side         = 1'b1;
        cur.chk_res          = 1'b1;
        cur.exp_out.valid    = 1'b1;
        cur.exp_out.rd       = 5'd3;
        cur.exp_out.wr_rd    = 1'b1;
        cur.exp_out.result   = res;
    endtask

    task automatic br_vec(input ex1_pkg::br_op_t b, input logic [31:0] pc, input logic [31:0] imm,
                          input logic [31:0] rjd, input logic [31:0] rkd, input logic pt,
                          input logic [31:0] pp, input logic tk, input logic [31:0] tpc,
                          input logic dirf, input logic addrf, input logic link);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_rf, ex1_pkg::src2_rf, rjd, rkd, imm, pc + 32'd4);
        cur.iss.pc           = pc;
        cur.iss.uop.br_op    = b;
        cur.iss.uop.link     = link;
        cur.iss.uop.wr_rd    = link;
        cur.exp_out.wr_rd    = link;
        cur.chk_res          = link;
        cur.rnd_side         = 1'b0;
        cur.ptaken           = pt;
        cur.ppc              = pp;
        cur.exp_br.is_branch = 1'b1;
        cur.exp_br.taken     = tk;
        cur.exp_br.fact_pc   = pc;
        cur.exp_br.fact_tpc  = tpc;
        cur.exp_br.dir_fail  = dirf;
        cur.exp_br.addr_fail = addrf;
    endtask

    task automatic mem_vec(input ex1_pkg::mem_op_t m, input ex1_pkg::mem_size_t sz,
                           input logic [31:0] rkd, input logic [31:0] imm, input logic [3:0] wt,
                           input logic [31:0] addr, input logic [31:0] wd, input logic wr,
                           input logic atom);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 32'h1000_0000, rkd, imm, 0);
        cur.chk_res          = 1'b0;
        cur.iss.uop.mem_op   = m;
        cur.iss.uop.mem_size = sz;
        cur.exp_dc.valid     = 1'b1;
        cur.exp_dc.op        = wr;
        cur.exp_dc.wtype     = wt;
        cur.exp_dc.addr      = addr;
        cur.exp_dc.wdata     = wd;
        cur.exp_dc.is_atom   = atom;
    endtask

    task automatic set_slot(input int k, input logic [4:0] rd, input logic [31:0] d, input logic v);
        cur.fwd[k].rd         = rd;
        cur.fwd[k].data       = d;
        cur.fwd[k].data_valid = v;
    endtask

    task automatic build_table();
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 5, 7, 0, 32'd12);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_sub, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 5, 7, 0, 32'hFFFF_FFFE);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_slt, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 32'hFFFF_FFFF, 1, 0, 1);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_sltu, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 32'hFFFF_FFFF, 1, 0, 0);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_and, ex1_pkg::src1_rf, ex1_pkg::src2_rf,
                32'hF0F0_F0F0, 32'hFF00_FF00, 0, 32'hF000_F000);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_or, ex1_pkg::src1_rf, ex1_pkg::src2_rf,
                32'hF0F0_F0F0, 32'hFF00_FF00, 0, 32'hFFF0_FFF0);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_xor, ex1_pkg::src1_rf, ex1_pkg::src2_rf,
                32'hF0F0_F0F0, 32'hFF00_FF00, 0, 32'h0FF0_0FF0);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_nor, ex1_pkg::src1_rf, ex1_pkg::src2_rf,
                32'hF0F0_F0F0, 32'hFF00_FF00, 0, 32'h000F_000F);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_sll, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 1, 32'h24, 0, 32'h10);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_srl, ex1_pkg::src1_rf, ex1_pkg::src2_rf,
                32'h8000_0000, 4, 0, 32'h0800_0000);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_sra, ex1_pkg::src1_rf, ex1_pkg::src2_rf,
                32'h8000_0000, 4, 0, 32'hF800_0000);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_pass_b, ex1_pkg::src1_zero, ex1_pkg::src2_imm,
                32'hDEAD_BEEF, 0, 32'h1234_5000, 32'h1234_5000);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_pc, ex1_pkg::src2_imm, 9, 9, 32'h2000, 32'h1C00_2000);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_tid, ex1_pkg::src2_imm, 9, 9, 0, 32'h7);
        cur.rnd_side = 1'b0;
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_zero, ex1_pkg::src2_cntl, 9, 9, 0, 32'h3333_4444);
        cur.rnd_side = 1'b0;
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_zero, ex1_pkg::src2_cnth, 9, 9, 0, 32'h1111_2222);
        cur.rnd_side = 1'b0;
        vecs.push_back(cur);
        // youngest valid wins, invalid match falls through
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 1, 2, 0, 32'h120);
        cur.iss.rj = 5'd4;
        cur.iss.rk = 5'd5;
        set_slot(0, 5'd4, 32'h100, 1'b1);
        set_slot(1, 5'd5, 32'h10, 1'b0);
        set_slot(2, 5'd4, 32'h200, 1'b1);
        set_slot(3, 5'd5, 32'h20, 1'b1);
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 3, 4, 0, 32'd7);
        cur.iss.rj = 5'd0;
        cur.iss.rk = 5'd0;
        for (int k = 0; k < `EX1_FWD_SLOTS; k++) begin
            set_slot(k, 5'd0, 32'h999, 1'b1);
        end
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_beq, 32'h1C00_0200, 32'h40, 32'h55, 32'h55, 1, 32'h1C00_0240,
               1, 32'h1C00_0240, 0, 0, 0);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_bne, 32'h1C00_0200, 32'h40, 32'h55, 32'h55, 1, 32'h1C00_0240,
               0, 32'h1C00_0240, 1, 0, 0);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_blt, 32'h1C00_0300, 32'hFFFF_FF00, 32'hFFFF_FFFF, 1, 1, 32'h1C00_0000,
               1, 32'h1C00_0200, 0, 1, 0);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_bge, 32'h1C00_0400, 32'h8, 32'hFFFF_FFFF, 1, 0, 0,
               0, 32'h1C00_0408, 0, 0, 0);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_bltu, 32'h1C00_0500, 32'h10, 32'hFFFF_FFFF, 1, 1, 32'h1C00_0510,
               0, 32'h1C00_0510, 1, 0, 0);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_bgeu, 32'h1C00_0600, 32'h20, 32'hFFFF_FFFF, 1, 0, 0,
               1, 32'h1C00_0620, 1, 0, 0);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_bl, 32'h1C00_0700, 32'h100, 0, 0, 1, 32'h1C00_0800,
               1, 32'h1C00_0800, 0, 0, 1);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_jirl, 32'h1C00_0800, 32'h10, 32'h1C00_1000, 0, 1, 32'h1C00_1010,
               1, 32'h1C00_1010, 0, 0, 1);
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_b, 32'h1C00_0900, 32'h40, 0, 0, 0, 0, 1, 32'h1C00_0940, 1, 0, 0);
        vecs.push_back(cur);
        mem_vec(ex1_pkg::mem_load, ex1_pkg::size_byte, 32'hAABB_CCDD, 3, 4'b1000,
                32'h1000_0003, 32'hDDDD_DDDD, 0, 0);
        vecs.push_back(cur);
        mem_vec(ex1_pkg::mem_store, ex1_pkg::size_byte, 32'hAABB_CCDD, 3, 4'b1000,
                32'h1000_0003, 32'hDDDD_DDDD, 1, 0);
        vecs.push_back(cur);
        mem_vec(ex1_pkg::mem_store, ex1_pkg::size_half, 32'h1234_5678, 2, 4'b1100,
                32'h1000_0002, 32'h5678_5678, 1, 0);
        vecs.push_back(cur);
        mem_vec(ex1_pkg::mem_store, ex1_pkg::size_word, 32'h1234_5678, 4, 4'b1111,
                32'h1000_0004, 32'h1234_5678, 1, 0);
        vecs.push_back(cur);
        mem_vec(ex1_pkg::mem_atomic, ex1_pkg::size_word, 32'h1234_5678, 8, 4'b1111,
                32'h1000_0008, 32'h1234_5678, 0, 1);
        vecs.push_back(cur);
        // valid low and flush must drop every valid bit
        mem_vec(ex1_pkg::mem_store, ex1_pkg::size_word, 1, 0, 4'b1111, 32'h1000_0000, 1, 1, 0);
        cur.iss.valid = 1'b0;
        cur.iss.uop.br_op = ex1_pkg::br_b;
        cur.exp_out.valid = 1'b0;
        cur.exp_dc = '0;
        vecs.push_back(cur);
        br_vec(ex1_pkg::br_bl, 32'h1C00_0A00, 32'h40, 0, 0, 0, 0, 1, 32'h1C00_0A40, 0, 0, 1);
        cur.flush = 1'b1;
        cur.exp_out.valid = 1'b0;
        cur.exp_br = '0;
        vecs.push_back(cur);
        alu_vec(ex1_pkg::alu_add, ex1_pkg::src1_rf, ex1_pkg::src2_rf, 1, 1, 0, 32'd2);
        vecs.push_back(cur);
    endtask

    initial begin
        wait (n_vec > 0);
        #((n_vec + 20) * 100);
        $display("timeout: run did not finish within %0d cycles", n_vec + 20);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        vec_t        v;
        logic [63:0] r;
        rst_n  = 1'b0;
        flush  = 1'b0;
        issue  = '0;
        tid    = '0;
        cnt    = '0;
        ptaken = 1'b0;
        ppc    = '0;
        for (int k = 0; k < `EX1_FWD_SLOTS; k++) begin
            fwd[k] = '0;
        end
        build_table();
        n_vec = vecs.size();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            @(posedge clk);
            v = vecs[i];
            if (v.rnd_side) begin
                r = take_bits(32);
                v.tid = r[31:0];
                v.cnt = take_bits(64);
                r = take_bits(1);
                v.ptaken = r[0];
                r = take_bits(32);
                v.ppc = r[31:0];
            end
            for (int k = 0; k < `EX1_FWD_SLOTS; k++) begin
                if (!v.fwd[k].data_valid) begin
                    if (v.fwd[k].rd == 5'd0) begin  // keep a planted rd
                        r = take_bits(5);
                        v.fwd[k].rd = r[4:0];
                    end
                    r = take_bits(32);
                    v.fwd[k].data = r[31:0];
                end
                fwd[k] <= v.fwd[k];
            end
            issue    <= v.iss;
            tid      <= v.tid;
            cnt      <= v.cnt;
            ptaken   <= v.ptaken;
            ppc      <= v.ppc;
            flush    <= v.flush;
            cur_idx  <= i;
            cur_live <= 1'b1;
        end
        @(posedge clk);
        issue.valid <= 1'b0;
        cur_live    <= 1'b0;
        repeat (3) @(posedge clk);
        $display("errors: %0d, entries checked: %0d of %0d", errors, checked, n_vec);
        if (errors == 0 && checked == n_vec) begin
            $display("** PASS **");
        end else begin
            if (checked != n_vec) begin
                $display("checker compared fewer results than the table holds");
            end
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* ex1.f */
+incdir+rtl
rtl/ex1_pkg.sv
rtl/ex1_forward.sv
rtl/ex1_alu.sv
rtl/ex1_branch.sv
rtl/ex1_mem_req.sv
rtl/ex1_stage.sv
bench/ex1_checker.sv
bench/tb_ex1.sv

/* rtl/ex1_alu.sv */
`timescale 1ns/1ns
`include "ex1_cfg.svh"

module ex1_alu (
    input  ex1_pkg::alu_op_t op_i,
    input  ex1_pkg::word_t   a_i,
    input  ex1_pkg::word_t   b_i,
    output ex1_pkg::word_t   y_o
);

    logic [$clog2(`EX1_XLEN)-1:0] shamt;
    logic                         lt_s;
    logic                         lt_u;

    assign shamt = b_i[$clog2(`EX1_XLEN)-1:0];  // low 5 bits only
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ex1_pkg::alu_add: begin
                y_o = a_i + b_i;
            end
            ex1_pkg::alu_sub: begin
                y_o = a_i - b_i;
            end
            ex1_pkg::alu_slt: begin
                y_o = {{(`EX1_XLEN-1){1'b0}}, lt_s};
            end
            ex1_pkg::alu_sltu: begin
                y_o = {{(`EX1_XLEN-1){1'b0}}, lt_u};
            end
            ex1_pkg::alu_and: begin
                y_o = a_i & b_i;
            end
            ex1_pkg::alu_or: begin
                y_o = a_i | b_i;
            end
            ex1_pkg::alu_xor: begin
                y_o = a_i ^ b_i;
            end
            ex1_pkg::alu_nor: begin
                y_o = ~(a_i | b_i);
            end
            ex1_pkg::alu_sll: begin
                y_o = a_i << shamt;
            end
            ex1_pkg::alu_srl: begin
                y_o = a_i >> shamt;
            end
            ex1_pkg::alu_sra: begin
                y_o = $signed(a_i) >>> shamt;
            end
            ex1_pkg::alu_pass_b: begin
                y_o = b_i;
            end
            default: begin
                y_o = '0;
            end
        endcase
    end

endmodule

/* rtl/ex1_branch.sv */
`timescale 1ns/1ns

module ex1_branch (
    input  ex1_pkg::word_t   pc_i,
    input  ex1_pkg::word_t   imm_i,
    input  ex1_pkg::word_t   src1_i,
    input  ex1_pkg::word_t   src2_i,
    input  ex1_pkg::br_op_t  op_i,
    input  logic             predict_taken_i,
    input  ex1_pkg::word_t   predict_pc_i,
    output ex1_pkg::br_res_t res_o
);

    logic           is_br;
    logic           taken;
    logic           eq;
    logic           lt_s;
    logic           lt_u;
    ex1_pkg::word_t target;

    assign eq   = src1_i == src2_i;
    assign lt_s = $signed(src1_i) < $signed(src2_i);
    assign lt_u = src1_i < src2_i;
    assign is_br = op_i != ex1_pkg::br_none;

    always_comb begin
        case (op_i)
            ex1_pkg::br_beq: begin
                taken = eq;
            end
            ex1_pkg::br_bne: begin
                taken = !eq;
            end
            ex1_pkg::br_blt: begin
                taken = lt_s;
            end
            ex1_pkg::br_bge: begin
                taken = !lt_s;
            end
            ex1_pkg::br_bltu: begin
                taken = lt_u;
            end
            ex1_pkg::br_bgeu: begin
                taken = !lt_u;
            end
            ex1_pkg::br_b, ex1_pkg::br_bl, ex1_pkg::br_jirl: begin
                taken = 1'b1;  // unconditional
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target = (op_i == ex1_pkg::br_jirl) ? src1_i + imm_i : pc_i + imm_i;

    always_comb begin
        res_o.is_branch = is_br;
        res_o.taken     = taken;
        res_o.fact_pc   = pc_i;
        res_o.fact_tpc  = target;
        res_o.dir_fail  = is_br && (taken != predict_taken_i);
        // only meaningful when both sides agreed on taken
        res_o.addr_fail = is_br && taken && predict_taken_i && (target != predict_pc_i);
    end

endmodule

/* rtl/ex1_cfg.svh */
`ifndef EX1_CFG_SVH
`define EX1_CFG_SVH

// datapath
`define EX1_XLEN        32
`define EX1_REG_W       5
`define EX1_PC_STEP     4
`define EX1_ZERO_REG    0  // hard-wired r0

// producer slots: ex1/ex2 x2, ex2/wb x2
`define EX1_FWD_SLOTS   4

// micro-op field widths
`define EX1_ALU_OP_W    4
`define EX1_SEL_W       2
`define EX1_BR_OP_W     4
`define EX1_MEM_OP_W    2
`define EX1_MEM_SIZE_W  2

`endif

/* rtl/ex1_forward.sv */
`timescale 1ns/1ns
`include "ex1_cfg.svh"

module ex1_forward (
    input  ex1_pkg::reg_idx_t rj_i,
    input  ex1_pkg::reg_idx_t rk_i,
    input  ex1_pkg::word_t    rj_data_i,
    input  ex1_pkg::word_t    rk_data_i,
    input  ex1_pkg::fwd_src_t fwd_i [`EX1_FWD_SLOTS],
    output ex1_pkg::word_t    rj_data_o,
    output ex1_pkg::word_t    rk_data_o
);

    // slot 0 is the youngest producer
    function automatic ex1_pkg::word_t fwd_pick(
        input ex1_pkg::reg_idx_t idx,
        input ex1_pkg::word_t    rf_data,
        input ex1_pkg::fwd_src_t slots [`EX1_FWD_SLOTS]
    );
        ex1_pkg::word_t val;
        val = rf_data;
        if (idx != ex1_pkg::reg_idx_t'(`EX1_ZERO_REG)) begin
            // oldest first so younger hits overwrite
            for (int i = `EX1_FWD_SLOTS - 1; i >= 0; i--) begin
                if (slots[i].data_valid && slots[i].rd == idx) begin
                    val = slots[i].data;
                end
            end
        end
        return val;
    endfunction

    always_comb begin
        rj_data_o = fwd_pick(rj_i, rj_data_i, fwd_i);
        rk_data_o = fwd_pick(rk_i, rk_data_i, fwd_i);
    end

endmodule

/* rtl/ex1_mem_req.sv */
`timescale 1ns/1ns
`include "ex1_cfg.svh"

module ex1_mem_req (
    input  ex1_pkg::word_t       base_i,
    input  ex1_pkg::word_t       imm_i,
    input  ex1_pkg::word_t       store_data_i,
    input  ex1_pkg::mem_op_t     op_i,
    input  ex1_pkg::mem_size_t   size_i,
    output ex1_pkg::dcache_req_t req_o
);

    ex1_pkg::word_t                 addr;
    ex1_pkg::byte_mask_t            mask;
    ex1_pkg::word_t                 wdata;
    logic [$clog2(`EX1_XLEN/8)-1:0] ofs;  // byte offset in word

    assign addr = base_i + imm_i;
    assign ofs  = addr[$clog2(`EX1_XLEN/8)-1:0];

    always_comb begin
        case (size_i)
            ex1_pkg::size_byte: begin
                mask  = 4'b0001;
                wdata = {4{store_data_i[7:0]}};
            end
            ex1_pkg::size_half: begin
                mask  = 4'b0011;
                wdata = {2{store_data_i[15:0]}};
            end
            default: begin
                mask  = 4'b1111;
                wdata = store_data_i;
            end
        endcase
    end

    always_comb begin
        req_o.valid   = op_i != ex1_pkg::mem_none;
        req_o.op      = op_i == ex1_pkg::mem_store;
        req_o.wtype   = mask << ofs;
        req_o.addr    = addr;
        req_o.wdata   = wdata;  // replicated to every lane
        req_o.is_atom = op_i == ex1_pkg::mem_atomic;
    end

endmodule

/* rtl/ex1_pkg.sv */
`include "ex1_cfg.svh"

package ex1_pkg;

    typedef logic [`EX1_XLEN-1:0]   word_t;
    typedef logic [`EX1_REG_W-1:0]  reg_idx_t;
    typedef logic [`EX1_XLEN/8-1:0] byte_mask_t;

    typedef enum logic [`EX1_ALU_OP_W-1:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra,
        alu_pass_b  // lu12i style
    } alu_op_t;

    typedef enum logic [`EX1_SEL_W-1:0] {
        src1_rf, src1_pc, src1_zero, src1_tid
    } src1_sel_t;

    typedef enum logic [`EX1_SEL_W-1:0] {
        src2_rf, src2_imm, src2_cntl, src2_cnth
    } src2_sel_t;

    typedef enum logic [`EX1_BR_OP_W-1:0] {
        br_none, br_beq, br_bne, br_blt, br_bge,
        br_bltu, br_bgeu, br_b, br_bl, br_jirl
    } br_op_t;

    typedef enum logic [`EX1_MEM_OP_W-1:0] {
        mem_none, mem_load, mem_store, mem_atomic
    } mem_op_t;

    typedef enum logic [`EX1_MEM_SIZE_W-1:0] {
        size_byte, size_half, size_word
    } mem_size_t;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        br_op_t    br_op;
        mem_op_t   mem_op;
        mem_size_t mem_size;
        logic      link;   // writes pc+4
        logic      wr_rd;
    } uop_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        uop_t     uop;
        word_t    imm;
        reg_idx_t rj;
        reg_idx_t rk;
        reg_idx_t rd;
        word_t    rj_data;
        word_t    rk_data;
    } issue_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     data_valid;  // result computed yet
    } fwd_src_t;

    typedef struct packed {
        logic  is_branch;
        logic  taken;
        word_t fact_pc;
        word_t fact_tpc;
        logic  dir_fail;
        logic  addr_fail;
    } br_res_t;

    typedef struct packed {
        logic       valid;
        logic       op;     // 0 read, 1 write
        byte_mask_t wtype;
        word_t      addr;
        word_t      wdata;
        logic       is_atom;
    } dcache_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     wr_rd;
        word_t    result;
    } ex1_out_t;

endpackage

/* rtl/ex1_stage.sv */
`timescale 1ns/1ns
`include "ex1_cfg.svh"

module ex1_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  ex1_pkg::issue_t       issue_i,
    input  ex1_pkg::fwd_src_t     fwd_i [`EX1_FWD_SLOTS],
    input  ex1_pkg::word_t        tid_i,
    input  logic [2*`EX1_XLEN-1:0] stable_counter_i,
    input  logic                  predict_taken_i,
    input  ex1_pkg::word_t        predict_pc_i,
    output ex1_pkg::ex1_out_t     out_o,
    output ex1_pkg::br_res_t      br_o,
    output ex1_pkg::dcache_req_t  dcache_o
);

    ex1_pkg::word_t       rj_fwd;
    ex1_pkg::word_t       rk_fwd;
    ex1_pkg::word_t       alu_a;
    ex1_pkg::word_t       alu_b;
    ex1_pkg::word_t       alu_y;
    ex1_pkg::word_t       link_pc;
    ex1_pkg::br_res_t     br_d;
    ex1_pkg::dcache_req_t dc_d;
    ex1_pkg::ex1_out_t    out_d;
    logic                 live;

    ex1_pkg::ex1_out_t    out_q;
    ex1_pkg::br_res_t     br_q;
    ex1_pkg::dcache_req_t dc_q;
    logic                 out_vld_q;
    logic                 dc_vld_q;
    logic                 br_vld_q;
    logic                 dir_fail_q;
    logic                 addr_fail_q;

    ex1_forward u_forward (
        .rj_i      (issue_i.rj),
        .rk_i      (issue_i.rk),
        .rj_data_i (issue_i.rj_data),
        .rk_data_i (issue_i.rk_data),
        .fwd_i     (fwd_i),
        .rj_data_o (rj_fwd),
        .rk_data_o (rk_fwd)
    );

    always_comb begin
        case (issue_i.uop.src1_sel)
            ex1_pkg::src1_rf:   alu_a = rj_fwd;
            ex1_pkg::src1_pc:   alu_a = issue_i.pc;
            ex1_pkg::src1_zero: alu_a = '0;
            default:            alu_a = tid_i;  // rdcntid
        endcase
        case (issue_i.uop.src2_sel)
            ex1_pkg::src2_rf:   alu_b = rk_fwd;
            ex1_pkg::src2_imm:  alu_b = issue_i.imm;
            ex1_pkg::src2_cntl: alu_b = stable_counter_i[`EX1_XLEN-1:0];
            default:            alu_b = stable_counter_i[2*`EX1_XLEN-1:`EX1_XLEN];
        endcase
    end

    ex1_alu u_alu (
        .op_i (issue_i.uop.alu_op),
        .a_i  (alu_a),
        .b_i  (alu_b),
        .y_o  (alu_y)
    );

    ex1_branch u_branch (
        .pc_i            (issue_i.pc),
        .imm_i           (issue_i.imm),
        .src1_i          (rj_fwd),
        .src2_i          (rk_fwd),
        .op_i            (issue_i.uop.br_op),
        .predict_taken_i (predict_taken_i),
        .predict_pc_i    (predict_pc_i),
        .res_o           (br_d)
    );

    ex1_mem_req u_mem_req (
        .base_i       (rj_fwd),
        .imm_i        (issue_i.imm),
        .store_data_i (rk_fwd),
        .op_i         (issue_i.uop.mem_op),
        .size_i       (issue_i.uop.mem_size),
        .req_o        (dc_d)
    );

    assign link_pc = issue_i.pc + ex1_pkg::word_t'(`EX1_PC_STEP);
    assign live    = issue_i.valid && !flush_i;

    always_comb begin
        out_d.valid  = live;
        out_d.rd     = issue_i.rd;
        out_d.wr_rd  = issue_i.uop.wr_rd;
        out_d.result = issue_i.uop.link ? link_pc : alu_y;  // bl / jirl
    end

    // control flops
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_vld_q   <= 1'b0;
            dc_vld_q    <= 1'b0;
            br_vld_q    <= 1'b0;
            dir_fail_q  <= 1'b0;
            addr_fail_q <= 1'b0;
        end else begin
            out_vld_q   <= live;
            dc_vld_q    <= live && dc_d.valid;
            br_vld_q    <= live && br_d.is_branch;
            dir_fail_q  <= live && br_d.dir_fail;
            addr_fail_q <= live && br_d.addr_fail;
        end
    end

    always_ff @(posedge clk_i) begin
        out_q <= out_d;
        br_q  <= br_d;
        dc_q  <= dc_d;
    end

    always_comb begin
        out_o           = out_q;
        out_o.valid     = out_vld_q;
        br_o            = br_q;
        br_o.is_branch  = br_vld_q;
        br_o.dir_fail   = dir_fail_q;
        br_o.addr_fail  = addr_fail_q;
        dcache_o        = dc_q;
        dcache_o.valid  = dc_vld_q;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ex1 stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ex1.f --top-module tb_ex1 -o tb_ex1 > build.log 2>&1 &&
./obj_dir/tb_ex1 > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
